// File: all.f
hdl/bits_pkg.sv
hdl/bits_fill_ctrl.sv
hdl/bits_bit_buffer.sv
hdl/bits_instruction_cache.sv
verif/bits_instruction_cache_properties.sv
verif/bits_instruction_cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --assert -Wno-fatal \
  --top-module bits_instruction_cache_tb \
  -f all.f \
  -Mdir build/obj_dir -o bits_sim

# The log decides pass or fail
./build/obj_dir/bits_sim 2>&1 | tee build/sim.log

if grep -q "SIMULATION FAILED" build/sim.log; then
  echo "Test failed"
  exit 1
fi
if ! grep -q "SIMULATION PASSED" build/sim.log; then
  echo "Test did not complete"
  exit 1
fi
echo "Test passed"

// File: verif/bits_instruction_cache_tb.sv
`default_nettype none

module bits_instruction_cache_tb
  import bits_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 200;
  localparam take_code_t IDLE_CODE = 5'd31;

  logic clk;
  logic resetB;
  logic mem_req;
  logic mem_ack;
  word_t instruction_word;
  byte_mask_t valid_bytes;
  take_code_t instruction_process;
  cache_t instruction_cache;
  logic space_available;

  // Reference model state
  cache_t m_cache;
  int m_fill;
  logic m_ack;
  integer seed;

  bits_instruction_cache uut (
    .clk (clk),
    .resetB (resetB),
    .mem_req (mem_req),
    .mem_ack (mem_ack),
    .instruction_word (instruction_word),
    .valid_bytes (valid_bytes),
    .instruction_process (instruction_process),
    .instruction_cache (instruction_cache),
    .space_available (space_available)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Literal groups, then the two operator headers
  function automatic int rule_length(input take_code_t code);
    if (code < 5'd16)
      return 11 + 5 * int'(code);
    else if (code == 5'd16)
      return 22;
    else if (code == 5'd17)
      return 18;
    return 0;
  endfunction

  function automatic word_t random_word();
    return {$random(seed), $random(seed), $random(seed), $random(seed)};
  endfunction

  // Whole word lands below the held bits, zeros below the word
  function automatic void place_word(input word_t word, input byte_mask_t mask);
    int i;
    int pos;
    int bytes;
    bytes = 0;
    for (i = 0; i < WORD_BYTES; i++)
      bytes = bytes + int'(mask[i]);
    for (i = m_fill; i < CACHE_BITS; i++)
    begin
      pos = i - m_fill;
      m_cache[CACHE_BITS-1-i] = (pos < WORD_BITS) ? word[WORD_BITS-1-pos] : 1'b0;
    end
    m_fill = m_fill + 8 * bytes;
  endfunction

  always @(posedge clk or negedge resetB)
  begin : reference_model
    int len;
    logic take_ok;
    logic word_in;
    if (!resetB)
    begin
      m_cache = '0;
      m_fill = 0;
      m_ack = 1'b0;
    end
    else
    begin
      len = rule_length(instruction_process);
      take_ok = (int'(instruction_process) < TAKE_CODES) && (len <= m_fill);
      word_in = !m_ack && mem_req && (m_fill <= SPACE_LIMIT) && !take_ok;
      if (take_ok)
      begin
        m_cache = m_cache << len;
        m_fill = m_fill - len;
      end
      else if (word_in)
        place_word(instruction_word, valid_bytes);
      if (word_in)
        m_ack = 1'b1;
      else if (m_ack && !mem_req)
        m_ack = 1'b0;
    end
  end

  task automatic compare_cache(input string name, input cache_t actual, input cache_t expected);
    if (actual !== expected)
    begin
      $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("FAIL at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_model();
    @(negedge clk);
    compare_cache("instruction_cache", instruction_cache, m_cache);
    compare_flag("space_available", space_available, m_fill <= SPACE_LIMIT);
    compare_flag("mem_ack", mem_ack, m_ack);
  endtask

  task automatic wait_ack(input logic level);
    int n;
    @(negedge clk);
    for (n = 0; n < TIMEOUT && mem_ack !== level; n++)
      @(negedge clk);
    if (mem_ack !== level)
    begin
      $display("Timeout: mem_ack never went to %b within %0d cycles", level, TIMEOUT);
      $display("SIMULATION FAILED");
      $fatal(1);
    end
  endtask

  task automatic request_start(input word_t word, input byte_mask_t mask);
    @(posedge clk);
    mem_req <= 1'b1;
    instruction_word <= word;
    valid_bytes <= mask;
  endtask

  task automatic request_finish();
    wait_ack(1'b1);
    @(posedge clk);
    mem_req <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic transfer(input word_t word, input byte_mask_t mask);
    request_start(word, mask);
    request_finish();
  endtask

  // Code is seen at the second edge
  task automatic apply_take(input take_code_t code);
    @(posedge clk);
    instruction_process <= code;
    @(posedge clk);
    instruction_process <= IDLE_CODE;
    check_model();
  endtask

  task automatic test_reset();
    @(negedge clk);
    compare_cache("instruction_cache", instruction_cache, '0);
    compare_flag("space_available", space_available, 1'b1);
    compare_flag("mem_ack", mem_ack, 1'b0);
  endtask

  task automatic test_append();
    word_t w;
    w = random_word();
    transfer(w, 16'hffff);
    check_model();
    compare_cache("instruction_cache", instruction_cache, {w, {WORD_BITS{1'b0}}});
    transfer(random_word(), 16'h0f0f);
    check_model();
  endtask

  task automatic test_takes();
    int code;
    for (code = 0; code < TAKE_CODES; code++)
    begin
      while (m_fill <= SPACE_LIMIT)
        transfer(random_word(), 16'hffff);
      apply_take(take_code_t'(code));
    end
  endtask

  task automatic test_no_take();
    cache_t held;
    int code;
    held = m_cache;
    for (code = TAKE_CODES; code < 32; code++)
    begin
      apply_take(take_code_t'(code));
      compare_cache("instruction_cache", instruction_cache, held);
    end
    // Leave fewer bits than the longest literal group
    while (m_fill >= rule_length(5'd15))
      apply_take(5'd15);
    held = m_cache;
    apply_take(5'd15);
    compare_cache("instruction_cache", instruction_cache, held);
  endtask

  task automatic test_backpressure();
    int n;
    while (m_fill <= SPACE_LIMIT)
      transfer(random_word(), 16'hffff);
    request_start(random_word(), 16'hffff);
    for (n = 0; n < 20; n++)
    begin
      check_model();
      compare_flag("mem_ack", mem_ack, 1'b0);
    end
    while (m_fill > SPACE_LIMIT)
      apply_take(5'd0);
    request_finish();
    check_model();
    while (m_fill > SPACE_LIMIT)
      apply_take(5'd15);
    // Take code held together with a new request
    request_start(random_word(), 16'h00ff);
    instruction_process <= 5'd0;
    for (n = 0; n < 3; n++)
    begin
      check_model();
      compare_flag("mem_ack", mem_ack, 1'b0);
    end
    @(posedge clk);
    instruction_process <= IDLE_CODE;
    request_finish();
    check_model();
  endtask

  task automatic test_random();
    int op;
    int n;
    for (n = 0; n < 200; n++)
    begin
      op = $random(seed);
      if (op[0] && m_fill <= SPACE_LIMIT)
        transfer(random_word(), byte_mask_t'($random(seed)));
      else
        apply_take(take_code_t'($random(seed)));
      check_model();
    end
  endtask

  initial
  begin
    seed = 32'h1732ba2d;
    resetB = 1'b0;
    mem_req = 1'b0;
    instruction_word = '0;
    valid_bytes = '0;
    instruction_process = IDLE_CODE;
    repeat (10) @(posedge clk);
    resetB <= 1'b1;
    test_reset();
    test_append();
    test_takes();
    test_no_take();
    test_backpressure();
    test_random();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/bits_instruction_cache_properties.sv
`default_nettype none

module bits_instruction_cache_properties
  import bits_pkg::*;
(
  input logic clk,
  input logic resetB,
  input logic mem_req,
  input logic mem_ack,
  input fill_level_t fill_level
);

  timeunit 1ns;
  timeprecision 1ps;

  ack_rise_with_req: assert property (@(posedge clk) disable iff (!resetB)
    $rose(mem_ack) |-> mem_req)
    else $error("mem_ack rose while mem_req was low");

  ack_fall_after_req: assert property (@(posedge clk) disable iff (!resetB)
    $fell(mem_ack) |-> !$past(mem_req))
    else $error("mem_ack fell before mem_req went low");

  fill_in_range: assert property (@(posedge clk) disable iff (!resetB)
    fill_level <= fill_level_t'(CACHE_BITS))
    else $error("fill level above buffer size");

  ack_low_in_reset: assert property (@(posedge clk) !resetB |-> !mem_ack)
    else $error("mem_ack high during reset");

endmodule

bind bits_instruction_cache bits_instruction_cache_properties u_properties (
  .clk (clk),
  .resetB (resetB),
  .mem_req (mem_req),
  .mem_ack (mem_ack),
  .fill_level (u_bit_buffer.fill_level)
);

`default_nettype wire

// File: hdl/bits_instruction_cache.sv
`default_nettype none

module bits_instruction_cache
  import bits_pkg::*;
(
  input logic clk,
  input logic resetB,
  // Instruction memory
  input logic mem_req,
  output logic mem_ack,
  input word_t instruction_word,
  input byte_mask_t valid_bytes,
  // Decoder
  input take_code_t instruction_process,
  output cache_t instruction_cache,
  output logic space_available
);

  fill_t load;
  logic load_taken;

  // Memory-side handshake and byte count
  bits_fill_ctrl u_fill_ctrl (
    .clk (clk),
    .resetB (resetB),
    .mem_req (mem_req),
    .instruction_word (instruction_word),
    .valid_bytes (valid_bytes),
    .mem_ack (mem_ack),
    .space_available (space_available),
    .load_taken (load_taken),
    .load (load)
  );

  // Bit buffer with take and append
  bits_bit_buffer u_bit_buffer (
    .clk (clk),
    .resetB (resetB),
    .take (instruction_process),
    .load (load),
    .load_taken (load_taken),
    .instruction_cache (instruction_cache),
    .space_available (space_available)
  );

endmodule

`default_nettype wire

// File: hdl/bits_bit_buffer.sv
`default_nettype none

module bits_bit_buffer
  import bits_pkg::*;
(
  input logic clk,
  input logic resetB,
  // Consume request from the decoder
  input take_code_t take,
  // Append request from the fill control
  input fill_t load,
  output logic load_taken,
  output cache_t instruction_cache,
  output logic space_available
);

  fill_level_t fill_level;
  fill_level_t fill_next;
  fill_level_t take_len;
  logic take_code_ok;
  logic take_valid;
  cache_t cache_next;
  cache_t cache_shifted;
  cache_t word_placed;
  cache_t keep_mask;

  // Length in bits for one take code, zero for codes that take nothing
  function automatic fill_level_t take_length(input take_code_t code);
    fill_level_t len;
    begin
      len = '0;
      if (code < take_code_t'(LIT_CODES))
      begin
        len = LIT_BASE_BITS + LIT_STEP_BITS * fill_level_t'(code);
      end
      else if (code == OP_TYPE1_CODE)
      begin
        len = OP_TYPE1_BITS;
      end
      else if (code == OP_TYPE2_CODE)
      begin
        len = OP_TYPE2_BITS;
      end
      return len;
    end
  endfunction

  // Take decode
  always_comb
  begin
    take_len = take_length(take);
    take_code_ok = (take < take_code_t'(TAKE_CODES));
    // Never take more bits than the buffer holds
    take_valid = take_code_ok && (take_len <= fill_level);
  end

  // A take wins over an append in the same cycle
  assign load_taken = load.valid && !take_valid;

  // Oldest bits sit at the top, so consuming is a left shift
  assign cache_shifted = instruction_cache << take_len;

  // New word goes right below the bits already held
  assign word_placed = {load.word, {(CACHE_BITS - WORD_BITS){1'b0}}} >> fill_level;
  assign keep_mask = ~({CACHE_BITS{1'b1}} >> fill_level);

  always_comb
  begin
    cache_next = instruction_cache;
    fill_next = fill_level;
    if (take_valid)
    begin
      cache_next = cache_shifted;
      fill_next = fill_level - take_len;
    end
    else if (load_taken)
    begin
      cache_next = (instruction_cache & keep_mask) | word_placed;
      fill_next = fill_level + load.bits;
    end
  end

  always_ff @(posedge clk or negedge resetB)
  begin
    if (!resetB)
    begin
      instruction_cache <= '0;
      fill_level <= '0;
    end
    else
    begin
      instruction_cache <= cache_next;
      fill_level <= fill_next;
    end
  end

  // Room for one more full word
  assign space_available = (fill_level <= fill_level_t'(SPACE_LIMIT));

endmodule

`default_nettype wire

// File: hdl/bits_fill_ctrl.sv
`default_nettype none

module bits_fill_ctrl
  import bits_pkg::*;
(
  input logic clk,
  input logic resetB,
  // Instruction memory side
  input logic mem_req,
  input word_t instruction_word,
  input byte_mask_t valid_bytes,
  output logic mem_ack,
  // Buffer side
  input logic space_available,
  input logic load_taken,
  output fill_t load
);

  logic [BYTE_COUNT_BITS-1:0] byte_count;
  fill_level_t word_bits;
  fill_state_e state;
  fill_state_e state_next;

  // Count of valid bytes in the word
  always_comb
  begin
    byte_count = '0;
    for (int i = 0; i < WORD_BYTES; i++)
    begin
      byte_count = byte_count + (BYTE_COUNT_BITS)'(valid_bytes[i]);
    end
  end

  // Eight bits per valid byte
  assign word_bits = fill_level_t'({byte_count, 3'b000});

  // Offer the word while idle and the buffer has room
  always_comb
  begin
    load.valid = (state == FILL_IDLE) && mem_req && space_available;
    load.word = instruction_word;
    load.bits = word_bits;
  end

  // Four-phase handshake
  always_comb
  begin
    state_next = state;
    case (state)
      FILL_IDLE:
      begin
        // Buffer wrote the word at this edge
        if (load_taken)
        begin
          state_next = FILL_ACK;
        end
      end
      FILL_ACK:
      begin
        // Memory has withdrawn its request
        if (!mem_req)
        begin
          state_next = FILL_IDLE;
        end
      end
      default:
      begin
        state_next = FILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge resetB)
  begin
    if (!resetB)
    begin
      state <= FILL_IDLE;
    end
    else
    begin
      state <= state_next;
    end
  end

  // Ack comes straight from the state flop
  assign mem_ack = (state == FILL_ACK);

endmodule

`default_nettype wire

// File: hdl/bits_pkg.sv
`default_nettype none

package bits_pkg;

  // Buffer and memory word geometry
  localparam int CACHE_BITS = 256;
  localparam int WORD_BITS = 128;
  localparam int WORD_BYTES = 16;
  localparam int BYTE_COUNT_BITS = $clog2(WORD_BYTES + 1);

  // A new word is accepted only while at least one word of room is left
  localparam int SPACE_LIMIT = CACHE_BITS - WORD_BITS;

  // Take codes 0 to 17 carry a length, the rest take nothing
  localparam int TAKE_CODES = 18;
  localparam int TAKE_BITS = 5;

  // Plain vector types
  typedef logic [CACHE_BITS-1:0] cache_t;
  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [WORD_BYTES-1:0] byte_mask_t;
  typedef logic [$clog2(CACHE_BITS + 1)-1:0] fill_level_t;
  typedef logic [TAKE_BITS-1:0] take_code_t;

  // Field lengths of the bit-field format
  // Literal group n is one 5-bit nibble group longer than group n-1
  localparam fill_level_t LIT_BASE_BITS = 9'd11;
  localparam fill_level_t LIT_STEP_BITS = 9'd5;
  localparam int LIT_CODES = 16;

  // Operator headers
  localparam take_code_t OP_TYPE1_CODE = 5'd16;
  localparam take_code_t OP_TYPE2_CODE = 5'd17;
  localparam fill_level_t OP_TYPE1_BITS = 9'd22;
  localparam fill_level_t OP_TYPE2_BITS = 9'd18;

  // One word offered to the buffer by the memory side
  typedef struct packed {
    logic valid;
    word_t word;
    // Meaningful bits at the top of word, a multiple of 8
    fill_level_t bits;
  } fill_t;

  // Memory-side handshake
  typedef enum logic [0:0] {
    FILL_IDLE = 1'b0,
    FILL_ACK = 1'b1
  } fill_state_e;

endpackage

`default_nettype wire
